//--- Makefile
VERILATOR  ?= verilator
TOP        = mips_pipe_tb
FILELIST   = mips_pipe.f
OBJ_DIR    = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only --timing -sv
SIM_FLAGS  = --binary --timing --assert -sv -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- mips_pipe.f
+incdir+verif
src/mips_pkg.sv
src/mips_decode.sv
src/mips_reg_file.sv
src/mips_execute.sv
src/mips_result.sv
src/mips_pipe_top.sv
verif/mips_pipe_tb.sv

//--- src/mips_decode.sv
`timescale 1ns/1ns

module mips_decode
(
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_valid,
    input  mips_pkg::instr_t    instr,
    input  mips_pkg::word_t     rs_data,
    input  mips_pkg::word_t     rt_data,
    input  mips_pkg::reg_addr_t mem_dest,
    input  logic                mem_reg_write,
    output logic                instr_credit,
    output mips_pkg::reg_addr_t rs_addr,
    output mips_pkg::reg_addr_t rt_addr,
    output logic                ex_valid,
    output logic                ex_use_imm,
    output logic                ex_reg_write,
    output logic                ex_mem_read,
    output logic                ex_mem_write,
    output mips_pkg::alu_op_e   ex_alu_op,
    output mips_pkg::reg_addr_t ex_dest,
    output mips_pkg::word_t     ex_rs_data,
    output mips_pkg::word_t     ex_rt_data,
    output mips_pkg::word_t     ex_imm
);
    import mips_pkg::*;

    typedef logic [$clog2(INSTR_QUEUE_DEPTH)-1:0] qptr_t;
    typedef logic [$clog2(INSTR_QUEUE_DEPTH):0]   qcount_t;

    instr_t    queue_mem [INSTR_QUEUE_DEPTH];
    qptr_t     wr_ptr;
    qptr_t     rd_ptr;
    qcount_t   count;
    instr_t    head;
    imm_t      imm_field;
    word_t     imm_ext;
    alu_op_e   fn_op;
    alu_op_e   dec_alu_op;
    reg_addr_t dec_dest;
    logic      dec_use_imm;
    logic      dec_reg_write;
    logic      dec_mem_read;
    logic      dec_mem_write;
    logic      use_rs;
    logic      use_rt;
    logic      ex_hit;
    logic      mem_hit;
    logic      rs_hazard;
    logic      rt_hazard;
    logic      issue;

    //////////////////////////////////////////////////
    // instruction queue

    always_ff @(posedge clk)
    begin
        if (instr_valid)
            queue_mem[wr_ptr] <= instr;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (instr_valid)
                wr_ptr <= wr_ptr + qptr_t'(1);
            if (issue)
                rd_ptr <= rd_ptr + qptr_t'(1);
            case ({instr_valid, issue})
                2'b10:   count <= count + qcount_t'(1);
                2'b01:   count <= count - qcount_t'(1);
                default: count <= count;  // none, or push and pop together
            endcase
        end
    end

    assign head         = queue_mem[rd_ptr];
    assign rs_addr      = head[25:21];
    assign rt_addr      = head[20:16];
    assign imm_field    = head[15:0];
    assign imm_ext      = {{16{imm_field[15]}}, imm_field};
    assign instr_credit = issue;  // one credit back per issued instruction

    //////////////////////////////////////////////////
    // control decode

    always_comb
    begin
        case (head[5:0])
            FN_ADD:  fn_op = ALU_ADD;
            FN_SUB:  fn_op = ALU_SUB;
            FN_AND:  fn_op = ALU_AND;
            FN_OR:   fn_op = ALU_OR;
            FN_SLT:  fn_op = ALU_SLT;
            default: fn_op = ALU_NOP;
        endcase
    end

    always_comb
    begin
        dec_alu_op    = ALU_NOP;  // anything unknown leaves no trace
        dec_use_imm   = 1'b0;
        dec_reg_write = 1'b0;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        dec_dest      = rt_addr;
        use_rs        = 1'b0;
        use_rt        = 1'b0;
        case (head[31:26])
            OP_RTYPE:
            begin
                if (fn_op != ALU_NOP)
                begin
                    dec_alu_op    = fn_op;
                    dec_reg_write = 1'b1;
                    dec_dest      = head[15:11];  // rd
                    use_rs        = 1'b1;
                    use_rt        = 1'b1;
                end
            end
            OP_ADDI, OP_LW:
            begin
                dec_alu_op    = ALU_ADD;
                dec_use_imm   = 1'b1;
                dec_reg_write = 1'b1;
                dec_mem_read  = (head[31:26] == OP_LW);
                use_rs        = 1'b1;
            end
            OP_SW:
            begin
                dec_alu_op    = ALU_ADD;
                dec_use_imm   = 1'b1;
                dec_mem_write = 1'b1;
                use_rs        = 1'b1;
                use_rt        = 1'b1;  // store data
            end
            default:
            begin
                dec_alu_op = ALU_NOP;
            end
        endcase
    end

    // results still in flight, wb is covered by register file write-through
    assign ex_hit    = ex_valid && ex_reg_write && (ex_dest != '0);
    assign mem_hit   = mem_reg_write && (mem_dest != '0);
    assign rs_hazard = use_rs && ((ex_hit && ex_dest == rs_addr) ||
                                  (mem_hit && mem_dest == rs_addr));
    assign rt_hazard = use_rt && ((ex_hit && ex_dest == rt_addr) ||
                                  (mem_hit && mem_dest == rt_addr));
    assign issue     = (count != '0) && !rs_hazard && !rt_hazard;

    //////////////////////////////////////////////////
    // decode to execute register

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ex_valid     <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end
        else
        begin
            ex_valid     <= issue;  // bubble while stalled
            ex_reg_write <= issue && dec_reg_write;
            ex_mem_read  <= issue && dec_mem_read;
            ex_mem_write <= issue && dec_mem_write;
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            ex_alu_op  <= dec_alu_op;
            ex_use_imm <= dec_use_imm;
            ex_dest    <= dec_dest;
            ex_rs_data <= rs_data;
            ex_rt_data <= rt_data;
            ex_imm     <= imm_ext;
        end
    end

    // the source must hold a credit for every word it sends
    a_queue_no_overflow: assert property (@(posedge clk) disable iff (reset)
        instr_valid |-> (count != qcount_t'(INSTR_QUEUE_DEPTH)) || issue);

endmodule

//--- src/mips_execute.sv
`timescale 1ns/1ns

module mips_execute
(
    input  logic                clk,
    input  logic                reset,
    input  logic                ex_valid,
    input  mips_pkg::alu_op_e   ex_alu_op,
    input  logic                ex_use_imm,
    input  logic                ex_reg_write,
    input  logic                ex_mem_read,
    input  logic                ex_mem_write,
    input  mips_pkg::reg_addr_t ex_dest,
    input  mips_pkg::word_t     ex_rs_data,
    input  mips_pkg::word_t     ex_rt_data,
    input  mips_pkg::word_t     ex_imm,
    output logic                mem_valid,
    output logic                mem_reg_write,
    output logic                mem_read,
    output logic                mem_write,
    output mips_pkg::reg_addr_t mem_dest,
    output mips_pkg::word_t     mem_alu_result,
    output mips_pkg::word_t     mem_store_data
);
    import mips_pkg::*;

    word_t operand_b;
    word_t alu_result;

    assign operand_b = ex_use_imm ? ex_imm : ex_rt_data;  // addi, lw, sw take the immediate

    always_comb
    begin
        case (ex_alu_op)
            ALU_AND: alu_result = ex_rs_data & operand_b;
            ALU_OR:  alu_result = ex_rs_data | operand_b;
            ALU_ADD: alu_result = ex_rs_data + operand_b;
            ALU_SUB: alu_result = ex_rs_data - operand_b;
            ALU_SLT: alu_result = word_t'(ex_rs_data < operand_b);  // unsigned
            default: alu_result = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // execute to memory register

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_valid     <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_read      <= 1'b0;
            mem_write     <= 1'b0;
        end
        else
        begin
            mem_valid     <= ex_valid;
            mem_reg_write <= ex_valid && ex_reg_write;  // bubbles never look like writers
            mem_read      <= ex_valid && ex_mem_read;
            mem_write     <= ex_valid && ex_mem_write;
        end
    end

    always_ff @(posedge clk)
    begin
        mem_dest       <= ex_dest;
        mem_alu_result <= alu_result;
        mem_store_data <= ex_rt_data;
    end

    // decode never builds an instruction that both loads and stores
    a_mem_rw_exclusive: assert property (@(posedge clk) disable iff (reset)
        ex_valid |-> !(ex_mem_read && ex_mem_write));

endmodule

//--- src/mips_pipe_top.sv
`timescale 1ns/1ns

module mips_pipe_top
(
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_valid,
    input  mips_pkg::instr_t    instr,
    output logic                instr_credit,
    output logic                wb_valid,
    output mips_pkg::reg_addr_t wb_reg,
    output mips_pkg::word_t     wb_data
);
    import mips_pkg::*;

    // register file read ports
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    // decode to execute
    logic      ex_valid;
    logic      ex_use_imm;
    logic      ex_reg_write;
    logic      ex_mem_read;
    logic      ex_mem_write;
    alu_op_e   ex_alu_op;
    reg_addr_t ex_dest;
    word_t     ex_rs_data;
    word_t     ex_rt_data;
    word_t     ex_imm;

    // execute to result, dest and reg_write also feed the hazard check
    logic      mem_valid;
    logic      mem_reg_write;
    logic      mem_read;
    logic      mem_write;
    reg_addr_t mem_dest;
    word_t     mem_alu_result;
    word_t     mem_store_data;

    mips_decode   decode_i   (.*);
    mips_reg_file reg_file_i (.*);
    mips_execute  execute_i  (.*);
    mips_result   result_i   (.*);

endmodule

//--- src/mips_pkg.sv
package mips_pkg;

    //////////////////////////////////////////////////
    // sizes

    localparam int NUM_REGS          = 32;
    localparam int MEM_WORDS         = 32;
    localparam int INSTR_QUEUE_DEPTH = 4;  // also the credits held by the source

    //////////////////////////////////////////////////
    // widths with a meaning

    typedef logic [31:0]                   word_t;      // register and memory data
    typedef logic [31:0]                   instr_t;
    typedef logic [$clog2(NUM_REGS)-1:0]   reg_addr_t;
    typedef logic [$clog2(MEM_WORDS)-1:0]  mem_addr_t;  // word index, not a byte address
    typedef logic [15:0]                   imm_t;

    //////////////////////////////////////////////////
    // instruction fields and alu codes

    typedef enum logic [5:0]
    {
        OP_RTYPE = 6'b000000,
        OP_ADDI  = 6'b001000,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_e;

    typedef enum logic [5:0]
    {
        FN_ADD = 6'b100000,
        FN_SUB = 6'b100010,
        FN_AND = 6'b100100,
        FN_OR  = 6'b100101,
        FN_SLT = 6'b101010
    } funct_e;

    typedef enum logic [2:0]
    {
        ALU_AND = 3'b000,
        ALU_OR  = 3'b001,
        ALU_ADD = 3'b010,
        ALU_NOP = 3'b100,  // result forced to zero
        ALU_SUB = 3'b110,
        ALU_SLT = 3'b111   // unsigned compare
    } alu_op_e;

endpackage

//--- src/mips_reg_file.sv
`timescale 1ns/1ns

module mips_reg_file
(
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    input  logic                wb_valid,
    input  mips_pkg::reg_addr_t wb_reg,
    input  mips_pkg::word_t     wb_data,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data
);
    import mips_pkg::*;

    word_t regs [NUM_REGS];

    // one read port with write-through from wb
    function automatic word_t read_port(input reg_addr_t addr,
                                        input word_t     stored,
                                        input logic      wvalid,
                                        input reg_addr_t waddr,
                                        input word_t     wdata);
        if (addr == '0)
            read_port = '0;  // r0 is hardwired
        else if (wvalid && waddr == addr)
            read_port = wdata;
        else
            read_port = stored;
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= word_t'(i);  // register i starts at i
        end
        else if (wb_valid && wb_reg != '0)
            regs[wb_reg] <= wb_data;
    end

    assign rs_data = read_port(rs_addr, regs[rs_addr], wb_valid, wb_reg, wb_data);
    assign rt_data = read_port(rt_addr, regs[rt_addr], wb_valid, wb_reg, wb_data);

endmodule

//--- src/mips_result.sv
`timescale 1ns/1ns

module mips_result
(
    input  logic                clk,
    input  logic                reset,
    input  logic                mem_valid,
    input  logic                mem_reg_write,
    input  logic                mem_read,
    input  logic                mem_write,
    input  mips_pkg::reg_addr_t mem_dest,
    input  mips_pkg::word_t     mem_alu_result,
    input  mips_pkg::word_t     mem_store_data,
    output logic                wb_valid,
    output mips_pkg::reg_addr_t wb_reg,
    output mips_pkg::word_t     wb_data
);
    import mips_pkg::*;

    word_t     data_mem [MEM_WORDS];
    mem_addr_t mem_index;
    word_t     load_data;
    word_t     wb_data_next;

    // low bits of the alu result pick the word
    assign mem_index    = mem_alu_result[$bits(mem_addr_t)-1:0];
    assign load_data    = data_mem[mem_index];
    assign wb_data_next = mem_read ? load_data : mem_alu_result;

    //////////////////////////////////////////////////
    // data memory

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < MEM_WORDS; i++)
                data_mem[i] <= word_t'(i);  // word i starts at i
        end
        else if (mem_valid && mem_write)
            data_mem[mem_index] <= mem_store_data;
    end

    //////////////////////////////////////////////////
    // memory to write-back register

    always_ff @(posedge clk)
    begin
        if (reset)
            wb_valid <= 1'b0;
        else
            wb_valid <= mem_valid && mem_reg_write && (mem_dest != '0);  // r0 writes vanish here
    end

    always_ff @(posedge clk)
    begin
        wb_reg  <= mem_dest;
        wb_data <= wb_data_next;
    end

endmodule

//--- verif/mips_ref.svh
`ifndef MIPS_REF_SVH
`define MIPS_REF_SVH

word_t model_regs [NUM_REGS];
word_t model_mem  [MEM_WORDS];

// same contents as the pipeline after reset
function automatic void model_reset();
    for (int i = 0; i < NUM_REGS; i++)
        model_regs[i] = word_t'(i);
    for (int i = 0; i < MEM_WORDS; i++)
        model_mem[i] = word_t'(i);
endfunction

// run one instruction in program order, queue the write-back it should make
function automatic void ref_exec(input instr_t word);
    logic [5:0] op;
    logic [5:0] fn;
    reg_addr_t  dest;
    word_t      a;
    word_t      b;
    word_t      imm;
    word_t      addr;
    word_t      value;
    logic       writes;
    op     = word[31:26];
    fn     = word[5:0];
    a      = model_regs[word[25:21]];
    b      = model_regs[word[20:16]];
    imm    = {{16{word[15]}}, word[15:0]};
    addr   = a + imm;
    dest   = word[20:16];  // rt unless r-type
    value  = '0;
    writes = 1'b0;
    case (op)
        OP_RTYPE:
        begin
            dest   = word[15:11];
            writes = 1'b1;
            case (fn)
                FN_ADD:  value = a + b;
                FN_SUB:  value = a - b;
                FN_AND:  value = a & b;
                FN_OR:   value = a | b;
                FN_SLT:  value = (a < b) ? 32'd1 : 32'd0;  // both unsigned
                default: writes = 1'b0;
            endcase
        end
        OP_ADDI:
        begin
            value  = addr;
            writes = 1'b1;
        end
        OP_LW:
        begin
            value  = model_mem[mem_addr_t'(addr)];
            writes = 1'b1;
        end
        OP_SW:   model_mem[mem_addr_t'(addr)] = b;
        default: writes = 1'b0;  // beq, j and the rest do nothing
    endcase
    if (writes && dest != '0)
    begin
        model_regs[dest] = value;
        exp_reg_q.push_back(dest);
        exp_data_q.push_back(value);
    end
endfunction

`endif

//--- verif/mips_pipe_tb.sv
`timescale 1ns/1ns

module mips_pipe_tb;
    import mips_pkg::*;

    localparam int NUM_RANDOM = 200;

    logic      clk;
    logic      reset;
    logic      instr_valid;
    instr_t    instr;
    logic      instr_credit;
    logic      wb_valid;
    reg_addr_t wb_reg;
    word_t     wb_data;

    int        credits;      // source side view of free queue slots
    int        num_instrs;
    int        check_count;
    int        error_count;
    reg_addr_t exp_reg_q [$];
    word_t     exp_data_q [$];
    instr_t    directed_q [$];

    `include "mips_ref.svh"

    mips_pipe_top dut_i (.*);

    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // instruction building

    function automatic instr_t rtype_word(input logic [5:0] fn, input reg_addr_t rd,
                                          input reg_addr_t rs, input reg_addr_t rt);
        rtype_word = {6'b000000, rs, rt, rd, 5'b00000, fn};
    endfunction

    function automatic instr_t itype_word(input logic [5:0] op, input reg_addr_t rt,
                                          input reg_addr_t rs, input imm_t imm);
        itype_word = {op, rs, rt, imm};
    endfunction

    function automatic instr_t random_instr();
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        imm_t      imm;
        rs  = reg_addr_t'($urandom_range(0, 7));  // few registers so many dependencies
        rt  = reg_addr_t'($urandom_range(0, 7));
        rd  = reg_addr_t'($urandom_range(0, 7));
        imm = imm_t'($urandom);
        case ($urandom_range(0, 9))
            0:       random_instr = rtype_word(FN_ADD, rd, rs, rt);
            1:       random_instr = rtype_word(FN_SUB, rd, rs, rt);
            2:       random_instr = rtype_word(FN_AND, rd, rs, rt);
            3:       random_instr = rtype_word(FN_OR, rd, rs, rt);
            4:       random_instr = rtype_word(FN_SLT, rd, rs, rt);
            5:       random_instr = itype_word(OP_ADDI, rt, rs, imm);
            6:       random_instr = itype_word(OP_LW, rt, rs, imm);
            7:       random_instr = itype_word(OP_SW, rt, rs, imm);
            8:       random_instr = rtype_word(6'b000000, rd, rs, rt);  // sll is unsupported
            default: random_instr = itype_word(6'b000100, rt, rs, imm);  // beq
        endcase
    endfunction

    function automatic void load_directed_program();
        directed_q.push_back(rtype_word(FN_ADD, 5'd10, 5'd1, 5'd2));
        directed_q.push_back(rtype_word(FN_SUB, 5'd11, 5'd5, 5'd3));
        directed_q.push_back(rtype_word(FN_AND, 5'd12, 5'd6, 5'd3));
        directed_q.push_back(rtype_word(FN_OR, 5'd13, 5'd4, 5'd9));
        directed_q.push_back(rtype_word(FN_SLT, 5'd14, 5'd2, 5'd3));
        directed_q.push_back(rtype_word(FN_SLT, 5'd15, 5'd3, 5'd2));
        directed_q.push_back(rtype_word(FN_SUB, 5'd16, 5'd2, 5'd7));   // wraps below zero
        directed_q.push_back(rtype_word(FN_SLT, 5'd17, 5'd16, 5'd1));  // unsigned gives 0
        directed_q.push_back(itype_word(OP_ADDI, 5'd18, 5'd5, 16'd100));
        directed_q.push_back(itype_word(OP_ADDI, 5'd19, 5'd5, 16'hfffd));
        directed_q.push_back(itype_word(OP_ADDI, 5'd20, 5'd0, 16'hffff));
        directed_q.push_back(itype_word(OP_SW, 5'd20, 5'd0, 16'd7));
        directed_q.push_back(itype_word(OP_LW, 5'd21, 5'd0, 16'd7));
        directed_q.push_back(itype_word(OP_LW, 5'd22, 5'd0, 16'd9));   // untouched word
        directed_q.push_back(itype_word(OP_LW, 5'd23, 5'd21, 16'd8));  // load after load
        directed_q.push_back(rtype_word(FN_ADD, 5'd24, 5'd23, 5'd23));
        directed_q.push_back(rtype_word(FN_SUB, 5'd25, 5'd24, 5'd1));
        directed_q.push_back(itype_word(OP_ADDI, 5'd25, 5'd25, 16'd1));
        directed_q.push_back(rtype_word(FN_OR, 5'd26, 5'd25, 5'd24));
        directed_q.push_back(rtype_word(FN_ADD, 5'd0, 5'd1, 5'd2));
        directed_q.push_back(itype_word(OP_ADDI, 5'd0, 5'd3, 16'd5));
        directed_q.push_back(itype_word(6'b000100, 5'd4, 5'd1, 16'd1));   // beq
        directed_q.push_back(itype_word(6'b000010, 5'd5, 5'd0, 16'd16));  // j
        directed_q.push_back(rtype_word(6'b000000, 5'd27, 5'd1, 5'd2));
        directed_q.push_back(rtype_word(FN_ADD, 5'd28, 5'd0, 5'd3));  // r0 must still read 0
    endfunction

    // one word per credit with valid held for one cycle
    task automatic send_instr(input instr_t word);
        while (credits == 0)
        begin
            instr_valid = 1'b0;
            @(negedge clk);
        end
        instr_valid = 1'b1;
        instr       = word;
        credits--;
        ref_exec(word);
        @(negedge clk);
    endtask

    //////////////////////////////////////////////////
    // credit return and result checking

    always @(posedge clk)
    begin
        if (!reset && instr_credit)
            credits++;
    end

    always @(posedge clk)
    begin
        reg_addr_t exp_reg;
        word_t     exp_data;
        if (!reset && wb_valid)
        begin
            assert (exp_reg_q.size() > 0)
            else
            begin
                error_count++;
                $display("write-back to r%0d at %0t with no write-back expected", wb_reg, $time);
            end
            if (exp_reg_q.size() > 0)
            begin
                exp_reg  = exp_reg_q.pop_front();
                exp_data = exp_data_q.pop_front();
                check_count++;
                assert (wb_reg == exp_reg && wb_data == exp_data)
                else
                begin
                    error_count++;
                    $display("Error at %0t: write-back r%0d = %h, expected r%0d = %h",
                             $time, wb_reg, wb_data, exp_reg, exp_data);
                end
            end
        end
    end

    initial
    begin
        wait (num_instrs > 0);
        repeat (num_instrs * 8 + 50) @(posedge clk);
        $display("watchdog expired after %0d cycles, pipeline never drained",
                 num_instrs * 8 + 50);
        $display("TEST FAIL");
        $finish;
    end

    //////////////////////////////////////////////////
    // main sequence

    initial
    begin
        int gap;
        void'($urandom(32'hc9450c2d));
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        credits     = INSTR_QUEUE_DEPTH;
        num_instrs  = 0;
        check_count = 0;
        error_count = 0;
        model_reset();
        load_directed_program();
        repeat (2) @(negedge clk);
        reset      = 1'b0;
        num_instrs = directed_q.size() + NUM_RANDOM;

        foreach (directed_q[i])
            send_instr(directed_q[i]);

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            gap = int'($urandom_range(0, 3));
            if (gap != 0)
            begin
                instr_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            send_instr(random_instr());
        end
        instr_valid = 1'b0;

        while (credits < INSTR_QUEUE_DEPTH)
            @(negedge clk);
        repeat (4) @(negedge clk);  // last issue reaches write-back in 3 cycles

        assert (exp_reg_q.size() == 0)
        else
        begin
            error_count++;
            $display("%0d expected write-backs never arrived", exp_reg_q.size());
        end
        assert (credits == INSTR_QUEUE_DEPTH)
        else
        begin
            error_count++;
            $display("credit count ended at %0d instead of %0d", credits, INSTR_QUEUE_DEPTH);
        end

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule
